// ==== design/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// Widths
`define XLEN          32
`define REG_ADDR_W    5
`define CSR_ADDR_W    12
`define INST_TYPE_W   3
`define ALU_OP_W      4
`define LSU_OP_W      3
`define CSR_OP_W      2

// Instruction types
`define INST_ALU_R    3'd0
`define INST_ALU_I    3'd1
`define INST_LOAD     3'd2
`define INST_STORE    3'd3
`define INST_CSR      3'd4

// ALU operations
`define ALU_ADD       4'd0
`define ALU_SUB       4'd1
`define ALU_AND       4'd2
`define ALU_OR        4'd3
`define ALU_XOR       4'd4
`define ALU_SLL       4'd5
`define ALU_SRL       4'd6
`define ALU_SRA       4'd7
`define ALU_SLT       4'd8
`define ALU_SLTU      4'd9
`define ALU_LUI       4'd10
`define ALU_AUIPC     4'd11

// Load and store operations
`define LSU_LB        3'd0
`define LSU_LH        3'd1
`define LSU_LW        3'd2
`define LSU_LBU       3'd3
`define LSU_LHU       3'd4
`define LSU_SB        3'd5
`define LSU_SH        3'd6
`define LSU_SW        3'd7

// CSR operations
`define CSR_RW        2'd0
`define CSR_RS        2'd1
`define CSR_RC        2'd2

`endif

// ==== design/exu_pkg.sv ====
`include "exu_params.svh"

package exu_pkg;

  typedef logic [`XLEN-1:0]        word_t;
  typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;
  typedef logic [`CSR_ADDR_W-1:0]  csr_addr_t;

  // Decoded instruction fields
  typedef logic [`INST_TYPE_W-1:0] inst_type_t;
  typedef logic [`ALU_OP_W-1:0]    alu_op_t;
  typedef logic [`LSU_OP_W-1:0]    lsu_op_t;
  typedef logic [`CSR_OP_W-1:0]    csr_op_t;

  // AXI side
  typedef logic [`XLEN/8-1:0]      strb_t;
  typedef logic [2:0]              axi_size_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_EXEC,
    S_AR,
    S_R,
    S_AW_W,
    S_B,
    S_DONE
  } exu_state_e;

endpackage

// ==== design/fu.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module fu (
  input  exu_pkg::inst_type_t inst_type_i,
  input  exu_pkg::alu_op_t    alu_op_i,
  input  exu_pkg::csr_op_t    csr_op_i,
  input  exu_pkg::word_t      pc_i,
  input  exu_pkg::word_t      imm_i,
  input  exu_pkg::word_t      rdata1_i,
  input  exu_pkg::word_t      rdata2_i,
  input  exu_pkg::word_t      csr_rdata_i,
  output exu_pkg::word_t      alu_result_o,
  output exu_pkg::word_t      csr_wdata_o
);
  import exu_pkg::*;

  word_t      op_b;
  word_t      alu_res;
  logic [4:0] shamt;

  assign op_b  = (inst_type_i == `INST_ALU_I) ? imm_i : rdata2_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op_i)
      `ALU_ADD:   alu_res = rdata1_i + op_b;
      `ALU_SUB:   alu_res = rdata1_i - op_b;
      `ALU_AND:   alu_res = rdata1_i & op_b;
      `ALU_OR:    alu_res = rdata1_i | op_b;
      `ALU_XOR:   alu_res = rdata1_i ^ op_b;
      `ALU_SLL:   alu_res = rdata1_i << shamt;
      `ALU_SRL:   alu_res = rdata1_i >> shamt;
      `ALU_SRA:   alu_res = word_t'($signed(rdata1_i) >>> shamt);
      `ALU_SLT:   alu_res = word_t'($signed(rdata1_i) < $signed(op_b));
      `ALU_SLTU:  alu_res = word_t'(rdata1_i < op_b);
      `ALU_LUI:   alu_res = imm_i;
      `ALU_AUIPC: alu_res = pc_i + imm_i;
      default:    alu_res = '0;
    endcase
  end

  // CSR instructions return the old CSR value to rd
  assign alu_result_o = (inst_type_i == `INST_CSR) ? csr_rdata_i : alu_res;

  always_comb begin
    case (csr_op_i)
      `CSR_RW: csr_wdata_o = rdata1_i;
      `CSR_RS: csr_wdata_o = csr_rdata_i | rdata1_i;
      `CSR_RC: csr_wdata_o = csr_rdata_i & ~rdata1_i;
      default: csr_wdata_o = csr_rdata_i;
    endcase
  end

endmodule

// ==== design/lsu.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module lsu (
  input  logic               clock_i,
  input  logic               arst_n_i,
  input  logic               load_we_i,
  input  exu_pkg::lsu_op_t   lsu_op_i,
  input  exu_pkg::word_t     imm_i,
  input  exu_pkg::word_t     rdata1_i,
  input  exu_pkg::word_t     rdata2_i,
  input  exu_pkg::word_t     rdata_i,
  output exu_pkg::word_t     mem_result_o,
  output exu_pkg::word_t     awaddr_o,
  output exu_pkg::axi_size_t awsize_o,
  output exu_pkg::word_t     wdata_o,
  output exu_pkg::strb_t     wstrb_o,
  output exu_pkg::word_t     araddr_o,
  output exu_pkg::axi_size_t arsize_o
);
  import exu_pkg::*;

  word_t      addr;
  logic [4:0] lane_shift;
  axi_size_t  size;
  word_t      store_val;
  strb_t      base_strb;
  word_t      lane;
  word_t      load_val;
  word_t      mem_result_q;

  assign addr       = rdata1_i + imm_i;
  assign lane_shift = {addr[1:0], 3'b000};

  always_comb begin
    case (lsu_op_i)
      `LSU_LB, `LSU_LBU, `LSU_SB: size = 3'd0;
      `LSU_LH, `LSU_LHU, `LSU_SH: size = 3'd1;
      default:                    size = 3'd2;
    endcase
  end

  assign awaddr_o = addr;
  assign araddr_o = addr;
  assign awsize_o = size;
  assign arsize_o = size;

  // Store data moved onto the addressed byte lanes
  assign store_val = (size == 3'd0) ? word_t'(rdata2_i[7:0]) :
                     (size == 3'd1) ? word_t'(rdata2_i[15:0]) : rdata2_i;
  assign base_strb = (size == 3'd0) ? 4'b0001 : (size == 3'd1) ? 4'b0011 : 4'b1111;
  assign wdata_o   = store_val << lane_shift;
  assign wstrb_o   = base_strb << addr[1:0];

  assign lane = rdata_i >> lane_shift;

  always_comb begin
    case (lsu_op_i)
      `LSU_LB:  load_val = {{24{lane[7]}}, lane[7:0]};
      `LSU_LBU: load_val = {24'b0, lane[7:0]};
      `LSU_LH:  load_val = {{16{lane[15]}}, lane[15:0]};
      `LSU_LHU: load_val = {16'b0, lane[15:0]};
      default:  load_val = lane;
    endcase
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mem_result_q <= '0;
    end else if (load_we_i) begin
      mem_result_q <= load_val;
    end
  end

  assign mem_result_o = mem_result_q;

  // Half and word loads must be naturally aligned when the read data arrives
  a_load_aligned: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    load_we_i |-> (size == 3'd0) || (size == 3'd1 && !addr[0]) || (addr[1:0] == 2'b00));

endmodule

// ==== design/execute_controller.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module execute_controller (
  input  logic                clock_i,
  input  logic                arst_n_i,

  input  logic                valid_pre_i,
  output logic                ready_pre_o,
  output logic                valid_post_o,
  input  logic                ready_post_i,

  input  exu_pkg::inst_type_t inst_type_i,
  output logic                capture_o,
  output logic                load_we_o,

  input  logic                awready_i,
  output logic                awvalid_o,
  input  logic                wready_i,
  output logic                wvalid_o,
  output logic                bready_o,
  input  logic                bvalid_i,
  input  logic                arready_i,
  output logic                arvalid_o,
  output logic                rready_o,
  input  logic                rvalid_i
);
  import exu_pkg::*;

  exu_state_e state_q;
  exu_state_e state_d;
  logic       aw_done_q;
  logic       w_done_q;
  logic       is_load;
  logic       is_store;
  logic       in_exec;
  logic       in_store;
  logic       aw_ok;
  logic       w_ok;

  assign is_load  = inst_type_i == `INST_LOAD;
  assign is_store = inst_type_i == `INST_STORE;
  assign in_exec  = state_q == S_EXEC;

  // S_EXEC already drives the first bus request or the result
  assign in_store     = (in_exec && is_store) || state_q == S_AW_W;
  assign awvalid_o    = in_store && !aw_done_q;
  assign wvalid_o     = in_store && !w_done_q;
  assign aw_ok        = aw_done_q || awready_i;
  assign w_ok         = w_done_q || wready_i;
  assign arvalid_o    = (in_exec && is_load) || state_q == S_AR;
  assign rready_o     = state_q == S_R;
  assign bready_o     = state_q == S_B;
  assign valid_post_o = (in_exec && !is_load && !is_store) || state_q == S_DONE;

  assign ready_pre_o = state_q == S_IDLE || (state_q == S_DONE && ready_post_i);
  assign capture_o   = valid_pre_i && ready_pre_o;
  assign load_we_o   = rready_o && rvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (capture_o) begin
          state_d = S_EXEC;
        end
      end
      S_EXEC: begin
        if (is_load) begin
          state_d = arready_i ? S_R : S_AR;
        end else if (is_store) begin
          state_d = (aw_ok && w_ok) ? S_B : S_AW_W;
        end else begin
          state_d = ready_post_i ? S_IDLE : S_DONE;
        end
      end
      S_AR: begin
        if (arready_i) begin
          state_d = S_R;
        end
      end
      S_R: begin
        if (rvalid_i) begin
          state_d = S_DONE;
        end
      end
      S_AW_W: begin
        if (aw_ok && w_ok) begin
          state_d = S_B;
        end
      end
      S_B: begin
        if (bvalid_i) begin
          state_d = S_DONE;
        end
      end
      S_DONE: begin
        if (ready_post_i) begin
          state_d = capture_o ? S_EXEC : S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= S_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Remember which write channel finished first
      if (in_store && !(aw_ok && w_ok)) begin
        aw_done_q <= aw_ok;
        w_done_q  <= w_ok;
      end else begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
    end
  end

  a_no_overlap: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    !(valid_post_o && (awvalid_o || wvalid_o || arvalid_o)));

  a_aw_hold: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    awvalid_o && !awready_i |=> awvalid_o);

endmodule

// ==== design/execute.sv ====
`timescale 1ns/100ps

module execute (
  input  logic                  clock_i,
  input  logic                  arst_n_i,

  input  logic                  valid_pre_i,
  output logic                  ready_pre_o,
  output logic                  valid_post_o,
  input  logic                  ready_post_i,

  input  exu_pkg::inst_type_t   inst_type_i,
  input  exu_pkg::alu_op_t      alu_op_i,
  input  exu_pkg::lsu_op_t      lsu_op_i,
  input  exu_pkg::csr_op_t      csr_op_i,
  input  logic                  wsel_i,
  input  logic                  wena_i,
  input  exu_pkg::reg_addr_t    waddr_i,
  input  logic                  csr_wena_i,
  input  exu_pkg::csr_addr_t    csr_waddr_i,
  input  exu_pkg::word_t        pc_i,
  input  exu_pkg::word_t        inst_i,
  input  exu_pkg::word_t        imm_i,
  input  exu_pkg::word_t        rdata1_i,
  input  exu_pkg::word_t        rdata2_i,
  input  exu_pkg::word_t        csr_rdata_i,

  output exu_pkg::word_t        pc_o,
  output exu_pkg::word_t        inst_o,
  output logic                  wsel_o,
  output logic                  wena_o,
  output exu_pkg::reg_addr_t    waddr_o,
  output exu_pkg::word_t        alu_result_o,
  output exu_pkg::word_t        mem_result_o,
  output logic                  csr_wena_o,
  output exu_pkg::csr_addr_t    csr_waddr_o,
  output exu_pkg::word_t        csr_wdata_o,

  // AXI4 write side
  input  logic                  awready_i,
  output logic                  awvalid_o,
  output exu_pkg::word_t        awaddr_o,
  output exu_pkg::axi_size_t    awsize_o,
  input  logic                  wready_i,
  output logic                  wvalid_o,
  output exu_pkg::word_t        wdata_o,
  output exu_pkg::strb_t        wstrb_o,
  output logic                  bready_o,
  input  logic                  bvalid_i,

  // AXI4 read side
  input  logic                  arready_i,
  output logic                  arvalid_o,
  output exu_pkg::word_t        araddr_o,
  output exu_pkg::axi_size_t    arsize_o,
  output logic                  rready_o,
  input  logic                  rvalid_i,
  input  exu_pkg::word_t        rdata_i
);
  import exu_pkg::*;

  logic       capture;
  logic       load_we;

  inst_type_t inst_type_q;
  alu_op_t    alu_op_q;
  lsu_op_t    lsu_op_q;
  csr_op_t    csr_op_q;
  logic       wsel_q;
  logic       wena_q;
  reg_addr_t  waddr_q;
  logic       csr_wena_q;
  csr_addr_t  csr_waddr_q;
  word_t      pc_q;
  word_t      inst_q;
  word_t      imm_q;
  word_t      rdata1_q;
  word_t      rdata2_q;
  word_t      csr_rdata_q;

  // Payload register, loaded once per accepted instruction
  always_ff @(posedge clock_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      {inst_type_q, alu_op_q, lsu_op_q, csr_op_q, wsel_q, wena_q, waddr_q,
       csr_wena_q, csr_waddr_q, pc_q, inst_q, imm_q, rdata1_q, rdata2_q,
       csr_rdata_q} <= '0;
    end else if (capture) begin
      {inst_type_q, alu_op_q, lsu_op_q, csr_op_q, wsel_q, wena_q, waddr_q,
       csr_wena_q, csr_waddr_q, pc_q, inst_q, imm_q, rdata1_q, rdata2_q,
       csr_rdata_q} <= {inst_type_i, alu_op_i, lsu_op_i, csr_op_i, wsel_i, wena_i,
                        waddr_i, csr_wena_i, csr_waddr_i, pc_i, inst_i, imm_i,
                        rdata1_i, rdata2_i, csr_rdata_i};
    end
  end

  assign pc_o        = pc_q;
  assign inst_o      = inst_q;
  assign wsel_o      = wsel_q;
  assign wena_o      = wena_q;
  assign waddr_o     = waddr_q;
  assign csr_wena_o  = csr_wena_q;
  assign csr_waddr_o = csr_waddr_q;

  execute_controller u_controller (
    .clock_i      (clock_i),
    .arst_n_i     (arst_n_i),
    .valid_pre_i  (valid_pre_i),
    .ready_pre_o  (ready_pre_o),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .inst_type_i  (inst_type_q),
    .capture_o    (capture),
    .load_we_o    (load_we),
    .awready_i    (awready_i),
    .awvalid_o    (awvalid_o),
    .wready_i     (wready_i),
    .wvalid_o     (wvalid_o),
    .bready_o     (bready_o),
    .bvalid_i     (bvalid_i),
    .arready_i    (arready_i),
    .arvalid_o    (arvalid_o),
    .rready_o     (rready_o),
    .rvalid_i     (rvalid_i)
  );

  fu u_fu (
    .inst_type_i  (inst_type_q),
    .alu_op_i     (alu_op_q),
    .csr_op_i     (csr_op_q),
    .pc_i         (pc_q),
    .imm_i        (imm_q),
    .rdata1_i     (rdata1_q),
    .rdata2_i     (rdata2_q),
    .csr_rdata_i  (csr_rdata_q),
    .alu_result_o (alu_result_o),
    .csr_wdata_o  (csr_wdata_o)
  );

  lsu u_lsu (
    .clock_i      (clock_i),
    .arst_n_i     (arst_n_i),
    .load_we_i    (load_we),
    .lsu_op_i     (lsu_op_q),
    .imm_i        (imm_q),
    .rdata1_i     (rdata1_q),
    .rdata2_i     (rdata2_q),
    .rdata_i      (rdata_i),
    .mem_result_o (mem_result_o),
    .awaddr_o     (awaddr_o),
    .awsize_o     (awsize_o),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .araddr_o     (araddr_o),
    .arsize_o     (arsize_o)
  );

  // Decode must hold its payload until the stage takes it
  a_pre_stable: assert property (@(posedge clock_i) disable iff (!arst_n_i)
    valid_pre_i && !ready_pre_o |=>
      $stable({inst_type_i, alu_op_i, lsu_op_i, csr_op_i, wsel_i, wena_i, waddr_i,
               csr_wena_i, csr_waddr_i, pc_i, inst_i, imm_i, rdata1_i, rdata2_i,
               csr_rdata_i}));

endmodule

// ==== test/tb_execute.sv ====
`timescale 1ns/100ps

`include "exu_params.svh"

module tb_execute;

  typedef struct {
    string       name;
    logic [2:0]  typ;
    logic [3:0]  op;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] imm;
    logic [31:0] csr;
    logic [31:0] exp1;
    logic [31:0] exp2;
    logic [3:0]  strb;
    logic [2:0]  size;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [19:0] side;
  } test_t;

  logic        clock_i;
  logic        arst_n_i;
  logic        valid_pre_i;
  logic        ready_pre_o;
  logic        valid_post_o;
  logic        ready_post_i;
  logic [2:0]  inst_type_i;
  logic [3:0]  alu_op_i;
  logic [2:0]  lsu_op_i;
  logic [1:0]  csr_op_i;
  logic        wsel_i;
  logic        wena_i;
  logic [4:0]  waddr_i;
  logic        csr_wena_i;
  logic [11:0] csr_waddr_i;
  logic [31:0] pc_i;
  logic [31:0] inst_i;
  logic [31:0] imm_i;
  logic [31:0] rdata1_i;
  logic [31:0] rdata2_i;
  logic [31:0] csr_rdata_i;
  logic [31:0] pc_o;
  logic [31:0] inst_o;
  logic        wsel_o;
  logic        wena_o;
  logic [4:0]  waddr_o;
  logic [31:0] alu_result_o;
  logic [31:0] mem_result_o;
  logic        csr_wena_o;
  logic [11:0] csr_waddr_o;
  logic [31:0] csr_wdata_o;
  logic        awready_i;
  logic        awvalid_o;
  logic [31:0] awaddr_o;
  logic [2:0]  awsize_o;
  logic        wready_i;
  logic        wvalid_o;
  logic [31:0] wdata_o;
  logic [3:0]  wstrb_o;
  logic        bready_o;
  logic        bvalid_i;
  logic        arready_i;
  logic        arvalid_o;
  logic [31:0] araddr_o;
  logic [2:0]  arsize_o;
  logic        rready_o;
  logic        rvalid_i;
  logic [31:0] rdata_i;

  test_t       tests[$];
  test_t       rt;
  logic [31:0] mem [64];
  int          acc_cnt = 0;
  int          res_cnt = 0;
  int          cur_idx = 0;
  bit          check_next = 0;
  logic [2:0]  next_type;
  string       next_name;
  bit          hold_prev = 0;
  logic [291:0] snap;
  logic [291:0] out_bus;
  int unsigned cycles = 0;

  assign out_bus = {pc_o, inst_o, wsel_o, wena_o, waddr_o, alu_result_o, mem_result_o,
                    csr_wena_o, csr_waddr_o, csr_wdata_o, valid_post_o, awvalid_o,
                    wvalid_o, arvalid_o, rready_o, bready_o, awaddr_o, awsize_o, wdata_o,
                    wstrb_o, araddr_o, arsize_o};

  execute dut_i (.*);

  initial begin
    clock_i = 1'b0;
    forever #10 clock_i = ~clock_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [319:0] expected,
                             input logic [319:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("Mismatch %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  task automatic add_test(input string name, input logic [2:0] typ, input logic [3:0] op,
                          input logic [31:0] rs1, input logic [31:0] rs2,
                          input logic [31:0] imm, input logic [31:0] csr,
                          input logic [31:0] exp1, input logic [31:0] exp2,
                          input logic [3:0] strb, input logic [2:0] size);
    test_t t;
    t.name = name;
    t.typ  = typ;
    t.op   = op;
    t.rs1  = rs1;
    t.rs2  = rs2;
    t.imm  = imm;
    t.csr  = csr;
    t.exp1 = exp1;
    t.exp2 = exp2;
    t.strb = strb;
    t.size = size;
    t.pc   = '0;
    t.inst = '0;
    t.side = '0;
    tests.push_back(t);
  endtask

  // exp1 is alu_result, mem_result or awaddr, exp2 is csr_wdata, wdata or araddr
  task automatic build_table();
    add_test("add_r", `INST_ALU_R, `ALU_ADD, 32'h0000_1234, 32'h0000_0F0F, 32'h5, 32'h0,
             32'h0000_2143, 32'h0, 4'h0, 3'd0);
    add_test("sub_r", `INST_ALU_R, `ALU_SUB, 32'h0000_0010, 32'h0000_0020, 32'h5, 32'h0,
             32'hFFFF_FFF0, 32'h0, 4'h0, 3'd0);
    add_test("and_r", `INST_ALU_R, `ALU_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 32'h5, 32'h0,
             32'h00F0_1200, 32'h0, 4'h0, 3'd0);
    add_test("or_r", `INST_ALU_R, `ALU_OR, 32'hA000_0005, 32'h0500_00A0, 32'h5, 32'h0,
             32'hA500_00A5, 32'h0, 4'h0, 3'd0);
    add_test("xor_r", `INST_ALU_R, `ALU_XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'h5, 32'h0,
             32'hF0F0_0F0F, 32'h0, 4'h0, 3'd0);
    add_test("sll_r", `INST_ALU_R, `ALU_SLL, 32'h0000_0003, 32'h0000_0024, 32'h5, 32'h0,
             32'h0000_0030, 32'h0, 4'h0, 3'd0);
    add_test("srl_r", `INST_ALU_R, `ALU_SRL, 32'h8000_0000, 32'h0000_001F, 32'h5, 32'h0,
             32'h0000_0001, 32'h0, 4'h0, 3'd0);
    add_test("sra_r", `INST_ALU_R, `ALU_SRA, 32'h8000_0000, 32'h0000_0004, 32'h5, 32'h0,
             32'hF800_0000, 32'h0, 4'h0, 3'd0);
    add_test("slt_r", `INST_ALU_R, `ALU_SLT, 32'hFFFF_FFFF, 32'h0000_0001, 32'h5, 32'h0,
             32'h0000_0001, 32'h0, 4'h0, 3'd0);
    add_test("sltu_r", `INST_ALU_R, `ALU_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 32'h5, 32'h0,
             32'h0000_0000, 32'h0, 4'h0, 3'd0);
    add_test("addi", `INST_ALU_I, `ALU_ADD, 32'h0000_0100, 32'hDEAD_BEEF, 32'hFFFF_FFFC,
             32'h0, 32'h0000_00FC, 32'h0, 4'h0, 3'd0);
    add_test("andi", `INST_ALU_I, `ALU_AND, 32'h1234_5678, 32'hDEAD_BEEF, 32'h0000_0FF0,
             32'h0, 32'h0000_0670, 32'h0, 4'h0, 3'd0);
    add_test("xori", `INST_ALU_I, `ALU_XOR, 32'h0000_00FF, 32'hDEAD_BEEF, 32'hFFFF_FFFF,
             32'h0, 32'hFFFF_FF00, 32'h0, 4'h0, 3'd0);
    add_test("srai", `INST_ALU_I, `ALU_SRA, 32'hF000_0000, 32'hDEAD_BEEF, 32'h0000_0404,
             32'h0, 32'hFF00_0000, 32'h0, 4'h0, 3'd0);
    add_test("slti", `INST_ALU_I, `ALU_SLT, 32'h0000_0005, 32'hDEAD_BEEF, 32'hFFFF_FFF0,
             32'h0, 32'h0000_0000, 32'h0, 4'h0, 3'd0);
    add_test("sltiu", `INST_ALU_I, `ALU_SLTU, 32'h0000_0005, 32'hDEAD_BEEF, 32'hFFFF_FFF0,
             32'h0, 32'h0000_0001, 32'h0, 4'h0, 3'd0);
    add_test("lui", `INST_ALU_I, `ALU_LUI, 32'hAAAA_AAAA, 32'hDEAD_BEEF, 32'h1234_5000,
             32'h0, 32'h1234_5000, 32'h0, 4'h0, 3'd0);
    // Entry 17, so pc is 8000_0044
    add_test("auipc", `INST_ALU_I, `ALU_AUIPC, 32'hAAAA_AAAA, 32'hDEAD_BEEF, 32'h0000_1000,
             32'h0, 32'h8000_1044, 32'h0, 4'h0, 3'd0);
    add_test("csrrw", `INST_CSR, `CSR_RW, 32'h0000_00FF, 32'h0, 32'h0, 32'h1234_5678,
             32'h1234_5678, 32'h0000_00FF, 4'h0, 3'd0);
    add_test("csrrs", `INST_CSR, `CSR_RS, 32'h0000_000F, 32'h0, 32'h0, 32'h1234_5670,
             32'h1234_5670, 32'h1234_567F, 4'h0, 3'd0);
    add_test("csrrc", `INST_CSR, `CSR_RC, 32'h0000_0FF0, 32'h0, 32'h0, 32'h1234_5678,
             32'h1234_5678, 32'h1234_5008, 4'h0, 3'd0);
    add_test("sw", `INST_STORE, `LSU_SW, 32'h0000_0040, 32'hCAFE_F00D, 32'h0, 32'h0,
             32'h0000_0040, 32'hCAFE_F00D, 4'hF, 3'd2);
    add_test("sh_hi", `INST_STORE, `LSU_SH, 32'h0000_0044, 32'h1111_BEEF, 32'h2, 32'h0,
             32'h0000_0046, 32'hBEEF_0000, 4'hC, 3'd1);
    add_test("sb_lane1", `INST_STORE, `LSU_SB, 32'h0000_0050, 32'hFFFF_FFA5, 32'hFFFF_FFF9,
             32'h0, 32'h0000_0049, 32'h0000_A500, 4'h2, 3'd0);
    add_test("sb_lane3", `INST_STORE, `LSU_SB, 32'h0000_004B, 32'h0000_007E, 32'h0, 32'h0,
             32'h0000_004B, 32'h7E00_0000, 4'h8, 3'd0);
    add_test("lw", `INST_LOAD, `LSU_LW, 32'h0000_003C, 32'h0, 32'h4, 32'h0,
             32'hCAFE_F00D, 32'h0000_0040, 4'h0, 3'd2);
    add_test("lh_hi", `INST_LOAD, `LSU_LH, 32'h0000_0046, 32'h0, 32'h0, 32'h0,
             32'hFFFF_BEEF, 32'h0000_0046, 4'h0, 3'd1);
    add_test("lhu_lo", `INST_LOAD, `LSU_LHU, 32'h0000_0040, 32'h0, 32'h4, 32'h0,
             32'h0000_D111, 32'h0000_0044, 4'h0, 3'd1);
    add_test("lb_neg", `INST_LOAD, `LSU_LB, 32'h0000_0049, 32'h0, 32'h0, 32'h0,
             32'hFFFF_FFA5, 32'h0000_0049, 4'h0, 3'd0);
    add_test("lbu", `INST_LOAD, `LSU_LBU, 32'h0000_0048, 32'h0, 32'h1, 32'h0,
             32'h0000_00A5, 32'h0000_0049, 4'h0, 3'd0);
    add_test("lb_pos", `INST_LOAD, `LSU_LB, 32'h0000_004B, 32'h0, 32'h0, 32'h0,
             32'h0000_007E, 32'h0000_004B, 4'h0, 3'd0);
    add_test("lw_fill", `INST_LOAD, `LSU_LW, 32'h0000_0100, 32'h0, 32'hFFFF_FFFC, 32'h0,
             32'hBF7F_FF3F, 32'h0000_00FC, 4'h0, 3'd2);
    add_test("lh_fill", `INST_LOAD, `LSU_LH, 32'h0000_000A, 32'h0, 32'h0, 32'h0,
             32'hFFFF_8242, 32'h0000_000A, 4'h0, 3'd1);
    add_test("or_last", `INST_ALU_R, `ALU_OR, 32'h0000_0000, 32'h5A5A_5A5A, 32'h5, 32'h0,
             32'h5A5A_5A5A, 32'h0, 4'h0, 3'd0);
    add_test("ori", `INST_ALU_I, `ALU_OR, 32'h0000_F000, 32'hDEAD_BEEF, 32'h0000_00F0,
             32'h0, 32'h0000_F0F0, 32'h0, 4'h0, 3'd0);
    add_test("slli", `INST_ALU_I, `ALU_SLL, 32'h0000_0001, 32'hDEAD_BEEF, 32'h0000_0028,
             32'h0, 32'h0000_0100, 32'h0, 4'h0, 3'd0);
    add_test("srli", `INST_ALU_I, `ALU_SRL, 32'h8000_0000, 32'hDEAD_BEEF, 32'h0000_0404,
             32'h0, 32'h0800_0000, 32'h0, 4'h0, 3'd0);
  endtask

  initial begin
    void'($urandom(29125));
    build_table();
    arst_n_i    <= 1'b0;
    valid_pre_i <= 1'b0;
    inst_type_i <= '0;
    alu_op_i    <= '0;
    lsu_op_i    <= '0;
    csr_op_i    <= '0;
    {wsel_i, wena_i, waddr_i, csr_wena_i, csr_waddr_i} <= '0;
    pc_i        <= '0;
    inst_i      <= '0;
    imm_i       <= '0;
    rdata1_i    <= '0;
    rdata2_i    <= '0;
    csr_rdata_i <= '0;
    repeat (10) @(posedge clock_i);
    arst_n_i <= 1'b1;
    @(posedge clock_i);
    check_value("reset handshake state", 7'b100_0000,
                {ready_pre_o, valid_post_o, arvalid_o, rready_o, awvalid_o, wvalid_o,
                 bready_o});
    check_value("reset mem_result", 32'h0, mem_result_o);

    for (int i = 0; i < tests.size(); i++) begin
      tests[i].pc   = 32'h8000_0000 | (i << 2);
      tests[i].inst = $urandom();
      tests[i].side = 20'($urandom());
      inst_type_i <= tests[i].typ;
      alu_op_i    <= tests[i].op;
      lsu_op_i    <= tests[i].op[2:0];
      csr_op_i    <= tests[i].op[1:0];
      imm_i       <= tests[i].imm;
      rdata1_i    <= tests[i].rs1;
      rdata2_i    <= tests[i].rs2;
      csr_rdata_i <= tests[i].csr;
      pc_i        <= tests[i].pc;
      inst_i      <= tests[i].inst;
      {wsel_i, wena_i, waddr_i, csr_wena_i, csr_waddr_i} <= tests[i].side;
      valid_pre_i <= 1'b1;
      do begin
        @(posedge clock_i);
      end while (!ready_pre_o);
      // Occasional bubble from decode
      if ($urandom_range(0, 3) == 0) begin
        valid_pre_i <= 1'b0;
        repeat ($urandom_range(1, 2)) @(posedge clock_i);
      end
    end
    valid_pre_i <= 1'b0;

    while (res_cnt < tests.size()) @(negedge clock_i);
    repeat (4) @(negedge clock_i);
    if (res_cnt == tests.size() && acc_cnt == tests.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_run("Number of results does not match the number of instructions sent");
    end
  end

  initial begin
    ready_post_i <= 1'b0;
    forever begin
      @(posedge clock_i);
      ready_post_i <= ($urandom_range(0, 2) != 0);
    end
  end

  // AXI memory with 0 to 3 cycles of delay on every channel
  initial begin : axi_memory
    int unsigned ar_cnt;
    int unsigned aw_cnt;
    int unsigned w_cnt;
    int unsigned r_cnt;
    int unsigned b_cnt;
    bit          r_pend;
    bit          b_pend;
    bit          aw_got;
    bit          w_got;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;
    for (int k = 0; k < 64; k++) begin
      mem[k] = {2'b10, k[5:0], 2'b01, k[5:0], 2'b11, k[5:0], 2'b00, k[5:0]};
    end
    ar_cnt = 0;
    aw_cnt = 0;
    w_cnt  = 0;
    r_pend = 0;
    b_pend = 0;
    aw_got = 0;
    w_got  = 0;
    arready_i <= 1'b1;
    awready_i <= 1'b1;
    wready_i  <= 1'b1;
    rvalid_i  <= 1'b0;
    bvalid_i  <= 1'b0;
    rdata_i   <= '0;
    forever begin
      @(posedge clock_i);
      if (arvalid_o && arready_i) begin
        check_value({tests[cur_idx].name, " read request type"}, `INST_LOAD,
                    tests[cur_idx].typ);
        check_value({tests[cur_idx].name, " araddr"}, tests[cur_idx].exp2, araddr_o);
        check_value({tests[cur_idx].name, " arsize"}, tests[cur_idx].size, arsize_o);
        rd_addr = araddr_o;
        r_pend  = 1;
        r_cnt   = $urandom_range(0, 3);
        ar_cnt  = $urandom_range(0, 3);
        arready_i <= (ar_cnt == 0);
      end else if (arvalid_o && ar_cnt != 0) begin
        ar_cnt--;
        arready_i <= (ar_cnt == 0);
      end

      if (rvalid_i && rready_o) begin
        rvalid_i <= 1'b0;
      end else if (r_pend) begin
        if (r_cnt == 0) begin
          rvalid_i <= 1'b1;
          rdata_i  <= mem[rd_addr[7:2]];
          r_pend = 0;
        end else begin
          r_cnt--;
        end
      end

      if (awvalid_o && awready_i) begin
        check_value({tests[cur_idx].name, " write request type"}, `INST_STORE,
                    tests[cur_idx].typ);
        check_value({tests[cur_idx].name, " awaddr"}, tests[cur_idx].exp1, awaddr_o);
        check_value({tests[cur_idx].name, " awsize"}, tests[cur_idx].size, awsize_o);
        wr_addr = awaddr_o;
        aw_got  = 1;
        aw_cnt  = $urandom_range(0, 3);
        awready_i <= (aw_cnt == 0);
      end else if (awvalid_o && aw_cnt != 0) begin
        aw_cnt--;
        awready_i <= (aw_cnt == 0);
      end

      if (wvalid_o && wready_i) begin
        check_value({tests[cur_idx].name, " wdata"}, tests[cur_idx].exp2, wdata_o);
        check_value({tests[cur_idx].name, " wstrb"}, tests[cur_idx].strb, wstrb_o);
        wr_data = wdata_o;
        wr_strb = wstrb_o;
        w_got   = 1;
        w_cnt   = $urandom_range(0, 3);
        wready_i <= (w_cnt == 0);
      end else if (wvalid_o && w_cnt != 0) begin
        w_cnt--;
        wready_i <= (w_cnt == 0);
      end

      if (aw_got && w_got) begin
        for (int b = 0; b < 4; b++) begin
          if (wr_strb[b]) begin
            mem[wr_addr[7:2]][8*b +: 8] = wr_data[8*b +: 8];
          end
        end
        aw_got = 0;
        w_got  = 0;
        b_pend = 1;
        b_cnt  = $urandom_range(0, 3);
      end

      if (bvalid_i && bready_o) begin
        bvalid_i <= 1'b0;
      end else if (b_pend) begin
        if (b_cnt == 0) begin
          bvalid_i <= 1'b1;
          b_pend = 0;
        end else begin
          b_cnt--;
        end
      end
    end
  end

  // Result order, hold under back-pressure and first-cycle timing
  always @(posedge clock_i) begin
    if (arst_n_i) begin
      if (check_next) begin
        case (next_type)
          `INST_LOAD:  check_value({next_name, " arvalid timing"}, 1'b1, arvalid_o);
          `INST_STORE: check_value({next_name, " aw/w valid timing"}, 2'b11,
                                   {awvalid_o, wvalid_o});
          default:     check_value({next_name, " valid_post timing"}, 1'b1, valid_post_o);
        endcase
        check_next = 0;
      end

      if (hold_prev) begin
        check_value({tests[res_cnt].name, " output hold"}, snap, out_bus);
      end
      hold_prev = valid_post_o && !ready_post_i;
      snap      = out_bus;

      if (valid_post_o && ready_post_i) begin
        if (res_cnt >= acc_cnt) begin
          fail_run("Result presented without an accepted instruction");
        end
        rt = tests[res_cnt];
        check_value({rt.name, " pc"}, rt.pc, pc_o);
        check_value({rt.name, " inst"}, rt.inst, inst_o);
        check_value({rt.name, " write-back fields"}, rt.side,
                    {wsel_o, wena_o, waddr_o, csr_wena_o, csr_waddr_o});
        case (rt.typ)
          `INST_LOAD: begin
            check_value({rt.name, " mem_result"}, rt.exp1, mem_result_o);
          end
          `INST_CSR: begin
            check_value({rt.name, " alu_result"}, rt.exp1, alu_result_o);
            check_value({rt.name, " csr_wdata"}, rt.exp2, csr_wdata_o);
          end
          `INST_ALU_R, `INST_ALU_I: begin
            check_value({rt.name, " alu_result"}, rt.exp1, alu_result_o);
          end
          default: begin
          end
        endcase
        res_cnt++;
      end

      if (valid_pre_i && ready_pre_o) begin
        if (acc_cnt >= tests.size()) begin
          fail_run("Stage accepted more instructions than were sent");
        end
        cur_idx    = acc_cnt;
        next_type  = inst_type_i;
        next_name  = tests[acc_cnt].name;
        check_next = 1;
        acc_cnt++;
      end
    end
  end

  always @(posedge clock_i) begin
    cycles <= cycles + 1;
    if (cycles > tests.size() * 64) begin
      fail_run("Timeout: the stage did not finish all instructions in time");
    end
  end

endmodule

// ==== tb.f ====
+incdir+design
design/exu_pkg.sv
design/fu.sv
design/lsu.sv
design/execute_controller.sv
design/execute.sv
test/tb_execute.sv

// ==== Bender.yml ====
package:
  name: execute

sources:
  - include_dirs:
      - design
    files:
      - design/exu_pkg.sv
      - design/fu.sv
      - design/lsu.sv
      - design/execute_controller.sv
      - design/execute.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_execute.sv
